// ==== logic/icache_defs.svh ====
/* Geometry and address field widths of the 2-way instruction cache.
   Included by the package and by every RTL file that sizes a port or a column. */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// 1 KB in total, 2 ways of 32 sets, 16-byte blocks
`define ICACHE_WAYS        2
`define ICACHE_SETS        32
`define ICACHE_INDEX_BITS  5    // log2 of the set count

// Byte address layout is [tag 23][index 5][word 2][byte 2]
`define IADDR_BITS         32
`define IBLOCK_OFFSET_BITS 4    // Byte offset within a block
`define IWORD_SEL_BITS     2    // Upper part of the block offset
`define ITAG_BITS          23

// Four 32-bit words per block, word 0 in bits [31:0]
`define IBLOCK_BITS        128

`endif

// ==== logic/icachePkg.sv ====
/* Types shared by the instruction cache RTL and its testbench.
   Field widths come from the geometry header. */
`include "icache_defs.svh"

package icachePkg;

    // Lookup request from the fetch stage
    typedef struct packed {
        logic [`ITAG_BITS+`ICACHE_INDEX_BITS-1:0] blockAddr;  // {tag, index}
        logic [`IWORD_SEL_BITS-1:0]               wordSel;
    } fetchReq_t;

    // Block read towards outside memory
    typedef struct packed {
        logic [`ITAG_BITS+`ICACHE_INDEX_BITS-1:0] blockAddr;
    } memReq_t;

    // Whole block coming back, also the fill payload
    typedef struct packed {
        logic [`IBLOCK_BITS-1:0] data;
    } memRsp_t;

    // Miss handling sequence
    typedef enum logic [2:0] {
        IDLE,
        REQUEST,   // memReqValid pulse
        WAIT,      // Memory latency
        FILL,      // Array write
        REPLAY     // Lookup again, now hits
    } refillState_t;

endpackage

// ==== logic/fetchStage.sv ====
/* Front end of the instruction cache: takes fetch strobes and splits the byte address.
   Drives the array lookup and returns the addressed word on a hit. */
`timescale 1ns/1ns
`include "icache_defs.svh"

module fetchStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetchValid,
    input  logic [`IADDR_BITS-1:0]  fetchAddr,
    input  logic [`IBLOCK_BITS-1:0] blockData,
    input  logic                    hit,
    input  logic                    replay,
    input  logic                    busy,
    output icachePkg::fetchReq_t    curReq,
    output logic                    lookupEn,
    output logic                    instrValid,
    output logic [31:0]             instr
);

    // Lowest bit of the word select inside the byte address
    localparam int WordLsb = `IBLOCK_OFFSET_BITS - `IWORD_SEL_BITS;

    logic strobeSeen;   // Lookup cycle of a fresh fetch

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            strobeSeen <= 1'b0;
        end else begin
            strobeSeen <= fetchValid;
        end
    end

    // Only a new strobe moves the request, so a replay sees the same address
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            curReq.blockAddr <= fetchAddr[`IADDR_BITS-1:`IBLOCK_OFFSET_BITS];
            curReq.wordSel   <= fetchAddr[`IBLOCK_OFFSET_BITS-1:WordLsb];
        end
    end

    // Replay is already one cycle wide from the refill FSM
    assign lookupEn = strobeSeen | replay;

    // Hit answers within the lookup cycle
    assign instrValid = lookupEn & hit;
    assign instr      = blockData[curReq.wordSel * 32 +: 32];   // Word 0 sits lowest

    // One miss outstanding at a time, so the requester holds off while busy
    noFetchWhileBusy: assert property (
        @(posedge clk) disable iff (!rst)
        busy |-> !fetchValid
    ) else $error("fetchValid strobed while cache busy");

    // Instruction fetches are word aligned
    alignedFetch: assert property (
        @(posedge clk) disable iff (!rst)
        fetchValid |-> (fetchAddr[WordLsb-1:0] == '0)
    ) else $error("unaligned fetch address %h", fetchAddr);

endmodule

// ==== logic/icacheArray.sv ====
/* Tag and data storage of the 2-way cache with combinational hit and victim choice.
   Refills write the pseudo-LRU victim of the addressed set on the clock edge. */
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheArray (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lookupEn,
    input  icachePkg::fetchReq_t    curReq,
    input  logic                    fillEn,
    input  icachePkg::memRsp_t      fillData,
    output logic                    hit,
    output logic [`IBLOCK_BITS-1:0] blockData
);

    logic [`ICACHE_WAYS-1:0] validCol  [`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0] statusCol [`ICACHE_SETS];   // Pseudo-LRU, one bit per way
    logic [`ITAG_BITS-1:0]   tagCol    [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`IBLOCK_BITS-1:0] dataCol   [`ICACHE_SETS][`ICACHE_WAYS];

    logic [`ICACHE_INDEX_BITS-1:0] index;
    logic [`ITAG_BITS-1:0]         tag;
    logic [`ICACHE_WAYS-1:0]       hitWay;
    logic [`ICACHE_WAYS-1:0]       victimWay;
    logic [`ICACHE_WAYS-1:0]       usedWay;
    logic [`ICACHE_WAYS-1:0]       nextStatus;
    logic                          victimFound;

    assign {tag, index} = curReq.blockAddr;

    // Tag compare across the ways of the set
    always_comb begin
        hitWay    = '0;
        blockData = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hitWay[w] = validCol[index][w] && (tagCol[index][w] == tag);
            if (hitWay[w]) begin
                blockData = dataCol[index][w];
            end
        end
    end

    assign hit = |hitWay;

    // Victim is the lowest way that is empty or not recently used
    always_comb begin
        victimWay   = '0;
        victimFound = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!victimFound && (!validCol[index][w] || !statusCol[index][w])) begin
                victimWay[w] = 1'b1;
                victimFound  = 1'b1;
            end
        end
        // A full set of status bits never survives an update
        if (!victimFound) begin
            victimWay[0] = 1'b1;
        end
    end

    // Status update for the way touched by a fill or a hit
    assign usedWay = fillEn ? victimWay : hitWay;

    always_comb begin
        nextStatus = statusCol[index] | usedWay;
        if (&nextStatus) begin
            nextStatus = usedWay;   // Set saturated, keep only the newest
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                validCol[s]  <= '0;
                statusCol[s] <= '0;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    tagCol[s][w]  <= '0;
                    dataCol[s][w] <= '0;
                end
            end
        end else if (fillEn) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (victimWay[w]) begin
                    validCol[index][w] <= 1'b1;
                    tagCol[index][w]   <= tag;
                    dataCol[index][w]  <= fillData.data;
                end
            end
            statusCol[index] <= nextStatus;
        end else if (lookupEn && hit) begin
            statusCol[index] <= nextStatus;
        end
    end

    // A block lives in at most one way of its set
    singleHitWay: assert property (
        @(posedge clk) disable iff (!rst)
        lookupEn |-> $onehot0(hitWay)
    ) else $error("multiple ways hit in set %0d", index);

    // Refill and lookup are serialized by the refill FSM
    noFillDuringLookup: assert property (
        @(posedge clk) disable iff (!rst)
        !(fillEn && lookupEn)
    ) else $error("fill collides with lookup");

    // The replay right after a fill must find the new block
    replayHitsAfterFill: assert property (
        @(posedge clk) disable iff (!rst)
        fillEn |=> (lookupEn && hit)
    ) else $error("replayed lookup missed after fill");

endmodule

// ==== logic/refillEngine.sv ====
/* Miss handling FSM of the instruction cache, one miss outstanding.
   Reads the block from memory, fills the array and replays the lookup. */
`timescale 1ns/1ns

module refillEngine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookupEn,
    input  logic                 hit,
    input  icachePkg::fetchReq_t curReq,
    input  logic                 memRspValid,
    input  icachePkg::memRsp_t   memRsp,
    output logic                 memReqValid,
    output icachePkg::memReq_t   memReq,
    output logic                 fillEn,
    output icachePkg::memRsp_t   fillData,
    output logic                 replay,
    output logic                 busy
);

    icachePkg::refillState_t state;
    icachePkg::refillState_t nextState;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= icachePkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            icachePkg::IDLE: begin
                if (lookupEn && !hit) begin
                    nextState = icachePkg::REQUEST;
                end
            end
            icachePkg::REQUEST: nextState = icachePkg::WAIT;
            icachePkg::WAIT: begin
                if (memRspValid) begin
                    nextState = icachePkg::FILL;
                end
            end
            icachePkg::FILL:    nextState = icachePkg::REPLAY;
            icachePkg::REPLAY:  nextState = icachePkg::IDLE;
            default:            nextState = icachePkg::IDLE;
        endcase
    end

    // Returned block, held for the fill cycle
    always_ff @(posedge clk) begin
        if (memRspValid && state == icachePkg::WAIT) begin
            fillData <= memRsp;
        end
    end

    // curReq stays put through the miss
    assign memReq.blockAddr = curReq.blockAddr;

    assign memReqValid = (state == icachePkg::REQUEST);
    assign fillEn      = (state == icachePkg::FILL);
    assign replay      = (state == icachePkg::REPLAY);
    assign busy        = (state != icachePkg::IDLE);

    // Memory only answers a request that was issued
    noStrayResponse: assert property (
        @(posedge clk) disable iff (!rst)
        (state == icachePkg::IDLE) |-> !memRspValid
    ) else $error("memRspValid without an outstanding request");

endmodule

// ==== logic/icacheTop.sv ====
/* Top of the read-only instruction cache.
   Connects the fetch stage, the tag/data array and the refill FSM to the ports. */
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchValid,
    input  logic [`IADDR_BITS-1:0] fetchAddr,
    output logic                   instrValid,
    output logic [31:0]            instr,
    output logic                   busy,
    output logic                   memReqValid,
    output icachePkg::memReq_t     memReq,
    input  logic                   memRspValid,
    input  icachePkg::memRsp_t     memRsp
);

    icachePkg::fetchReq_t    curReq;
    icachePkg::memRsp_t      fillData;
    logic [`IBLOCK_BITS-1:0] blockData;
    logic                    lookupEn;
    logic                    hit;
    logic                    fillEn;
    logic                    replay;

    fetchStage uFetch (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .blockData  (blockData),
        .hit        (hit),
        .replay     (replay),
        .busy       (busy),
        .curReq     (curReq),
        .lookupEn   (lookupEn),
        .instrValid (instrValid),
        .instr      (instr)
    );

    icacheArray uArray (
        .clk       (clk),
        .rst       (rst),
        .lookupEn  (lookupEn),
        .curReq    (curReq),
        .fillEn    (fillEn),
        .fillData  (fillData),
        .hit       (hit),
        .blockData (blockData)
    );

    refillEngine uRefill (
        .clk         (clk),
        .rst         (rst),
        .lookupEn    (lookupEn),
        .hit         (hit),
        .curReq      (curReq),
        .memRspValid (memRspValid),
        .memRsp      (memRsp),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .fillEn      (fillEn),
        .fillData    (fillData),
        .replay      (replay),
        .busy        (busy)
    );

endmodule

// ==== sim/icacheChecker.sv ====
/* Watches the cache ports on the falling edge and judges each fetch of the table.
   Prints one line per row and hands the error and row counts back to the testbench. */
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheChecker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchValid,
    input  logic [`IADDR_BITS-1:0] fetchAddr,
    input  logic                   instrValid,
    input  logic [31:0]            instr,
    input  logic                   busy,
    input  logic                   memReqValid,
    input  icachePkg::memReq_t     memReq,
    input  int                     rowIdx,
    input  logic                   expMiss,
    output int                     errorCount,
    output int                     rowsChecked
);

    logic                   pending;     // Fetch strobed, word not back yet
    logic [`IADDR_BITS-1:0] reqAddr;
    logic [31:0]            expected;
    int                     cycle;
    int                     strobeCycle;
    int                     memReqs;
    int                     rowErrors;

    initial begin
        errorCount  = 0;
        rowsChecked = 0;
        pending     = 1'b0;
        cycle       = 0;
    end

    task automatic judgeReturn();
        expected = {reqAddr[`IADDR_BITS-1:2], 2'b00} ^ 32'hA5A5_0000;
        if (instr !== expected) begin
            $display("MISMATCH at %0t ns: row %0d instr %h, expected %h",
                     $time, rowIdx, instr, expected);
            rowErrors++;
        end
        if (memReqs != (expMiss ? 1 : 0)) begin
            $display("MISMATCH at %0t ns: row %0d made %0d memory requests, expected %0d",
                     $time, rowIdx, memReqs, expMiss ? 1 : 0);
            rowErrors++;
        end
        if (!expMiss && (cycle - strobeCycle) != 1) begin
            $display("MISMATCH at %0t ns: row %0d hit took %0d cycles, expected 1",
                     $time, rowIdx, cycle - strobeCycle);
            rowErrors++;
        end
        $display("row %0d addr %h %s %s", rowIdx, reqAddr, expMiss ? "miss" : "hit",
                 (rowErrors == 0) ? "ok" : "FAILED");
        errorCount += rowErrors;
        rowsChecked++;
        pending = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            pending = 1'b0;
        end else begin
            if (fetchValid) begin
                rowErrors = 0;
                if (busy) begin
                    $display("Fetch of row %0d strobed while the cache was busy", rowIdx);
                    rowErrors++;
                end
                pending     = 1'b1;
                reqAddr     = fetchAddr;
                strobeCycle = cycle;
                memReqs     = 0;
            end
            if (memReqValid) begin
                memReqs++;
                if (memReq.blockAddr !== reqAddr[`IADDR_BITS-1:`IBLOCK_OFFSET_BITS]) begin
                    $display("MISMATCH at %0t ns: memory request for block %h, expected %h",
                             $time, memReq.blockAddr,
                             reqAddr[`IADDR_BITS-1:`IBLOCK_OFFSET_BITS]);
                    rowErrors++;
                end
            end
            if (instrValid) begin
                if (!pending) begin
                    $display("instrValid at %0t ns with no fetch outstanding", $time);
                    errorCount++;
                end else begin
                    judgeReturn();
                end
            end
        end
        cycle++;
    end

endmodule

// ==== sim/icacheTb.sv ====
/* Testbench top for the instruction cache: clock, reset, block memory model and a table
   of fetches driven one at a time. The checker module judges every returned word. */
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheTb;

    localparam int          NumRows        = 19;
    localparam int          CycleNs        = 10;
    localparam int          WatchdogCycles = NumRows * 20;
    localparam logic [31:0] Seed           = 32'h42a72a91;

    // One fetch of the table
    typedef struct packed {
        logic [`IADDR_BITS-1:0] addr;
        logic                   expMiss;
        logic                   resetFirst;   // Reset pulse before this row
    } stimRow_t;

    logic                   clk;
    logic                   rst;
    logic                   fetchValid;
    logic [`IADDR_BITS-1:0] fetchAddr;
    logic                   instrValid;
    logic [31:0]            instr;
    logic                   busy;
    logic                   memReqValid;
    icachePkg::memReq_t     memReq;
    logic                   memRspValid;
    icachePkg::memRsp_t     memRsp;

    stimRow_t                                    stimTable [NumRows];
    int                                          rowIdx;
    logic                                        expMiss;
    int                                          errorCount;
    int                                          rowsChecked;
    logic [`ITAG_BITS+`ICACHE_INDEX_BITS-1:0]    pendingBlock;
    int                                          delay;

    icacheTop DUT (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchAddr   (fetchAddr),
        .instrValid  (instrValid),
        .instr       (instr),
        .busy        (busy),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memRspValid (memRspValid),
        .memRsp      (memRsp)
    );

    icacheChecker uChecker (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchAddr   (fetchAddr),
        .instrValid  (instrValid),
        .instr       (instr),
        .busy        (busy),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .rowIdx      (rowIdx),
        .expMiss     (expMiss),
        .errorCount  (errorCount),
        .rowsChecked (rowsChecked)
    );

    initial begin
        clk = 1'b0;
        forever #(CycleNs / 2) clk = ~clk;
    end

    // Every word of a block is its own byte address XOR a constant
    function automatic logic [`IBLOCK_BITS-1:0] blockFor(
        input logic [`ITAG_BITS+`ICACHE_INDEX_BITS-1:0] blockAddr
    );
        logic [`IBLOCK_BITS-1:0] blk;
        for (int w = 0; w < 4; w++) begin
            blk[w*32 +: 32] = {blockAddr, 2'(w), 2'b00} ^ 32'hA5A5_0000;
        end
        return blk;
    endfunction

    // Memory answers each request 1 to 6 cycles later
    initial begin
        void'($urandom(Seed));   // Fixed delay sequence
        memRspValid = 1'b0;
        memRsp      = '0;
        forever begin
            @(negedge clk);
            if (memReqValid) begin
                pendingBlock = memReq.blockAddr;
                delay        = 1 + int'($urandom % 6);
                repeat (delay) @(posedge clk);
                #1;
                memRspValid = 1'b1;
                memRsp.data = blockFor(pendingBlock);
                @(posedge clk);
                #1;
                memRspValid = 1'b0;
            end
        end
    end

    // A, B and C share set 0
    task automatic loadTable();
        stimTable[0]  = '{32'h0000_1000, 1'b1, 1'b0};   // Cold A
        stimTable[1]  = '{32'h0000_1000, 1'b0, 1'b0};
        stimTable[2]  = '{32'h0000_1004, 1'b0, 1'b0};   // Remaining words of A
        stimTable[3]  = '{32'h0000_1008, 1'b0, 1'b0};
        stimTable[4]  = '{32'h0000_100C, 1'b0, 1'b0};
        stimTable[5]  = '{32'h0000_1200, 1'b1, 1'b0};   // B
        stimTable[6]  = '{32'h0000_1004, 1'b0, 1'b0};   // A touched again
        stimTable[7]  = '{32'h0000_1408, 1'b1, 1'b0};   // C evicts B
        stimTable[8]  = '{32'h0000_100C, 1'b0, 1'b0};
        stimTable[9]  = '{32'h0000_1204, 1'b1, 1'b0};   // B gone
        stimTable[10] = '{32'h0000_1204, 1'b0, 1'b0};
        stimTable[11] = '{32'h0000_1204, 1'b1, 1'b1};   // Reset drops B
        stimTable[12] = '{32'h0000_1000, 1'b1, 1'b0};
        stimTable[13] = '{32'hDEAD_BEE0, 1'b1, 1'b0};   // Other sets
        stimTable[14] = '{32'h0001_2344, 1'b1, 1'b0};
        stimTable[15] = '{32'h8000_0010, 1'b1, 1'b0};
        stimTable[16] = '{32'hDEAD_BEE8, 1'b0, 1'b0};
        stimTable[17] = '{32'h7FFF_FFFC, 1'b1, 1'b0};
        stimTable[18] = '{32'h0001_2340, 1'b0, 1'b0};
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
    endtask

    // One strobe, then hold until the word comes back
    task automatic runRow(input int r);
        @(posedge clk);
        #1;
        rowIdx     = r;
        expMiss    = stimTable[r].expMiss;
        fetchAddr  = stimTable[r].addr;
        fetchValid = 1'b1;
        @(posedge clk);
        #1;
        fetchValid = 1'b0;
        @(negedge clk);
        while (!instrValid) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst        = 1'b0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        rowIdx     = 0;
        expMiss    = 1'b0;
        loadTable();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int r = 0; r < NumRows; r++) begin
            if (stimTable[r].resetFirst) begin
                applyReset();
            end
            runRow(r);
        end
        @(posedge clk);
        $display("Summary: %0d of %0d rows checked, %0d errors",
                 rowsChecked, NumRows, errorCount);
        if (errorCount == 0 && rowsChecked == NumRows) begin
            $display("No errors");
        end else begin
            if (rowsChecked != NumRows) begin
                $display("Not every row returned an instruction");
            end
            $display("Errors found");
        end
        $finish;
    end

    // Generous bound per row, worst miss is well under 20 cycles
    initial begin
        #(WatchdogCycles * CycleNs);
        $display("Timeout: run did not finish within %0d cycles", WatchdogCycles);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/icachePkg.sv
logic/fetchStage.sv
logic/icacheArray.sv
logic/refillEngine.sv
logic/icacheTop.sv
sim/icacheChecker.sv
sim/icacheTb.sv

// ==== run.sh ====
#!/bin/bash
# Build the instruction cache testbench with Verilator, run it and judge the log
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    -f all.f --top-module icacheTb -o icacheSim
./obj_dir/icacheSim | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"
